/* mem_msg_pkg.sv */
// ------------------------------------------------
// Memory message definitions
// Field widths, op codes and packed widths of the
// request and response messages
// ------------------------------------------------

`default_nettype none

package mem_msg_pkg;

  // ------------------------------------------------
  // Field widths
  // ------------------------------------------------

  // Byte address carried in every message
  parameter int mem_addr_bits = 32;

  // Write data in requests, read data in responses
  parameter int mem_data_bits = 32;

  // Byte count, 0 stands for the full word
  parameter int mem_len_bits = 2;

  // Tag from the requester, echoed unchanged
  parameter int mem_opaque_bits = 8;

  // Read or write
  parameter int mem_op_bits = 1;

  // Bytes per memory word
  parameter int mem_bytes = 4;

  // ------------------------------------------------
  // Op codes
  // ------------------------------------------------

  parameter logic [mem_op_bits-1:0] mem_op_read = 1'b0;
  parameter logic [mem_op_bits-1:0] mem_op_write = 1'b1;

  // ------------------------------------------------
  // Packed message widths
  // ------------------------------------------------

  // Request layout, MSB first
  //   op | opaque | addr | len | data
  parameter int mem_req_bits = mem_op_bits
                             + mem_opaque_bits
                             + mem_addr_bits
                             + mem_len_bits
                             + mem_data_bits;

  // Response layout, same field order
  // Data is read data, or zero for a write
  parameter int mem_resp_bits = mem_op_bits
                              + mem_opaque_bits
                              + mem_addr_bits
                              + mem_len_bits
                              + mem_data_bits;

endpackage

`default_nettype wire

/* msg_queue.sv */
// ------------------------------------------------
// Message queue
// Val/rdy FIFO holding packed messages of any width
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module msg_queue #(
  parameter int width = 8,
  parameter int queue_depth = 4
) (
  input  logic             clk,
  input  logic             rst,

  input  logic             enq_val,
  output logic             enq_rdy,
  input  logic [width-1:0] enq_msg,

  output logic             deq_val,
  input  logic             deq_rdy,
  output logic [width-1:0] deq_msg
);

  // Pointer and count sizing
  localparam int ptr_bits = (queue_depth > 1) ? $clog2(queue_depth) : 1;
  localparam int cnt_bits = $clog2(queue_depth + 1);

  logic [width-1:0]    slots [0:queue_depth-1];
  logic [ptr_bits-1:0] wr_ptr;
  logic [ptr_bits-1:0] rd_ptr;
  logic [cnt_bits-1:0] count;
  logic                full;
  logic                do_enq;
  logic                do_deq;

  // Pointer step with wrap at the last slot
  function automatic logic [ptr_bits-1:0] next_ptr(input logic [ptr_bits-1:0] p);
    if (p == ptr_bits'(queue_depth - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  // ------------------------------------------------
  // Handshake
  // ------------------------------------------------

  assign full = (count == cnt_bits'(queue_depth));

  // Full queue still takes a message if one leaves now
  assign enq_rdy = !full || deq_rdy;
  assign deq_val = (count != '0);

  assign do_enq = enq_val && enq_rdy;
  assign do_deq = deq_val && deq_rdy;

  // Head of queue
  assign deq_msg = slots[rd_ptr];

  // ------------------------------------------------
  // Storage and pointers
  // ------------------------------------------------

  // Payload slots
  always_ff @(posedge clk) begin
    if (do_enq) begin
      slots[wr_ptr] <= enq_msg;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_enq) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_deq) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // Occupancy only moves when one side acts alone
      case ({do_enq, do_deq})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* mem_array.sv */
// ------------------------------------------------
// Word RAM
// Single port, registered read, byte write enables
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module mem_array #(
  parameter int words_log2 = 6
) (
  input  logic                                 clk,

  input  logic                                 ram_en,
  input  logic                                 ram_we,
  input  logic [mem_msg_pkg::mem_bytes-1:0]     ram_be,
  input  logic [words_log2-1:0]                ram_idx,
  input  logic [mem_msg_pkg::mem_data_bits-1:0] ram_wdata,
  output logic [mem_msg_pkg::mem_data_bits-1:0] ram_rdata
);

  import mem_msg_pkg::*;

  // Geometry
  localparam int depth = 2 ** words_log2;
  localparam int byte_bits = mem_data_bits / mem_bytes;

  // Word storage, contents undefined until written
  logic [mem_data_bits-1:0] words [0:depth-1];

  // ------------------------------------------------
  // Write port
  // ------------------------------------------------

  // Only enabled byte lanes change
  always_ff @(posedge clk) begin
    if (ram_en && ram_we) begin
      for (int b = 0; b < mem_bytes; b++) begin
        if (ram_be[b]) begin
          words[ram_idx][b*byte_bits +: byte_bits] <= ram_wdata[b*byte_bits +: byte_bits];
        end
      end
    end
  end

  // ------------------------------------------------
  // Read port
  // ------------------------------------------------

  // Registered read, valid one cycle after ram_en
  // Output holds between accesses
  always_ff @(posedge clk) begin
    if (ram_en) begin
      ram_rdata <= words[ram_idx];
    end
  end

endmodule

`default_nettype wire

/* mem_txn_engine.sv */
// ------------------------------------------------
// Memory transaction engine
// Stage 1 issues the RAM access, stage 2 masks the
// read data and offers the response
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module mem_txn_engine #(
  parameter int words_log2 = 6
) (
  input  logic                                 clk,
  input  logic                                 rst,

  // Request side
  input  logic                                 req_val,
  output logic                                 req_rdy,
  input  logic [mem_msg_pkg::mem_req_bits-1:0]  req_msg,

  // Response side
  output logic                                 resp_val,
  input  logic                                 resp_rdy,
  output logic [mem_msg_pkg::mem_resp_bits-1:0] resp_msg,

  // RAM port
  output logic                                 ram_en,
  output logic                                 ram_we,
  output logic [mem_msg_pkg::mem_bytes-1:0]     ram_be,
  output logic [words_log2-1:0]                ram_idx,
  output logic [mem_msg_pkg::mem_data_bits-1:0] ram_wdata,
  input  logic [mem_msg_pkg::mem_data_bits-1:0] ram_rdata
);

  import mem_msg_pkg::*;

  // Byte offset bits inside the address
  localparam int byte_off_bits = $clog2(mem_bytes);
  localparam int byte_bits = mem_data_bits / mem_bytes;

  // Request fields
  logic [mem_op_bits-1:0]     req_op;
  logic [mem_opaque_bits-1:0] req_opaque;
  logic [mem_addr_bits-1:0]   req_addr;
  logic [mem_len_bits-1:0]    req_len;
  logic [mem_data_bits-1:0]   req_data;

  // Stage 2 state
  logic                       s2_val;
  logic [mem_op_bits-1:0]     s2_op;
  logic [mem_opaque_bits-1:0] s2_opaque;
  logic [mem_addr_bits-1:0]   s2_addr;
  logic [mem_len_bits-1:0]    s2_len;
  logic [mem_bytes-1:0]       s2_be;
  logic [mem_data_bits-1:0]   resp_data;

  // Length to byte lanes, 0 selects the whole word
  function automatic logic [mem_bytes-1:0] len_to_be(input logic [mem_len_bits-1:0] len);
    logic [mem_bytes-1:0] be;
    be = '0;
    if (len == '0) begin
      be = '1;
    end else begin
      for (int i = 0; i < mem_bytes; i++) begin
        if (i < int'(len)) begin
          be[i] = 1'b1;
        end
      end
    end
    return be;
  endfunction

  // ------------------------------------------------
  // Stage 1: unpack and issue
  // ------------------------------------------------

  assign {req_op, req_opaque, req_addr, req_len, req_data} = req_msg;

  // Accept when stage 2 is free or empties this cycle
  assign req_rdy = !s2_val || resp_rdy;

  assign ram_en    = req_val && req_rdy;
  assign ram_we    = (req_op == mem_op_write);
  assign ram_be    = len_to_be(req_len);
  // Word index sits just above the byte offset
  assign ram_idx   = req_addr[byte_off_bits +: words_log2];
  assign ram_wdata = req_data;

  // ------------------------------------------------
  // Stage 2: hold request while data returns
  // ------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      s2_val <= 1'b0;
    end else if (req_rdy) begin
      s2_val <= req_val;
    end
  end

  // Payload fields, loaded on issue
  always_ff @(posedge clk) begin
    if (ram_en) begin
      s2_op     <= req_op;
      s2_opaque <= req_opaque;
      s2_addr   <= req_addr;
      s2_len    <= req_len;
    end
  end

  assign s2_be = len_to_be(s2_len);

  // Read data cut to requested bytes, writes return zero
  always_comb begin
    resp_data = '0;
    if (s2_op == mem_op_read) begin
      for (int b = 0; b < mem_bytes; b++) begin
        if (s2_be[b]) begin
          resp_data[b*byte_bits +: byte_bits] = ram_rdata[b*byte_bits +: byte_bits];
        end
      end
    end
  end

  assign resp_val = s2_val;
  assign resp_msg = {s2_op, s2_opaque, s2_addr, s2_len, resp_data};

endmodule

`default_nettype wire

/* mem_server.sv */
// ------------------------------------------------
// Memory server top level
// Request queue, transaction engine, word RAM and
// response queue on val/rdy streams
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module mem_server #(
  parameter int words_log2 = 6,
  parameter int queue_depth = 4
) (
  input  logic                                   clk,
  input  logic                                   rst,

  // Request stream
  input  logic                                   req_val,
  output logic                                   req_rdy,
  input  logic [mem_msg_pkg::mem_op_bits-1:0]     req_op,
  input  logic [mem_msg_pkg::mem_opaque_bits-1:0] req_opaque,
  input  logic [mem_msg_pkg::mem_addr_bits-1:0]   req_addr,
  input  logic [mem_msg_pkg::mem_len_bits-1:0]    req_len,
  input  logic [mem_msg_pkg::mem_data_bits-1:0]   req_data,

  // Response stream
  output logic                                   resp_val,
  input  logic                                   resp_rdy,
  output logic [mem_msg_pkg::mem_op_bits-1:0]     resp_op,
  output logic [mem_msg_pkg::mem_opaque_bits-1:0] resp_opaque,
  output logic [mem_msg_pkg::mem_addr_bits-1:0]   resp_addr,
  output logic [mem_msg_pkg::mem_len_bits-1:0]    resp_len,
  output logic [mem_msg_pkg::mem_data_bits-1:0]   resp_data
);

  import mem_msg_pkg::*;

  // Packed messages at the queue boundaries
  logic [mem_req_bits-1:0]  req_enq_msg;
  logic [mem_req_bits-1:0]  req_deq_msg;
  logic [mem_resp_bits-1:0] resp_enq_msg;
  logic [mem_resp_bits-1:0] resp_deq_msg;

  // Queue to engine handshakes
  logic deq_val;
  logic deq_rdy;
  logic enq_val;
  logic enq_rdy;

  // RAM port
  logic                     ram_en;
  logic                     ram_we;
  logic [mem_bytes-1:0]     ram_be;
  logic [words_log2-1:0]    ram_idx;
  logic [mem_data_bits-1:0] ram_wdata;
  logic [mem_data_bits-1:0] ram_rdata;

  // Field packing
  assign req_enq_msg = {req_op, req_opaque, req_addr, req_len, req_data};
  assign {resp_op, resp_opaque, resp_addr, resp_len, resp_data} = resp_deq_msg;

  // ------------------------------------------------
  // Instances
  // ------------------------------------------------

  msg_queue #(.width(mem_req_bits), .queue_depth(queue_depth)) req_queue (
    .clk(clk), .rst(rst),
    .enq_val(req_val), .enq_rdy(req_rdy), .enq_msg(req_enq_msg),
    .deq_val(deq_val), .deq_rdy(deq_rdy), .deq_msg(req_deq_msg)
  );

  mem_txn_engine #(.words_log2(words_log2)) engine (
    .clk(clk), .rst(rst),
    .req_val(deq_val), .req_rdy(deq_rdy), .req_msg(req_deq_msg),
    .resp_val(enq_val), .resp_rdy(enq_rdy), .resp_msg(resp_enq_msg),
    .ram_en(ram_en), .ram_we(ram_we), .ram_be(ram_be),
    .ram_idx(ram_idx), .ram_wdata(ram_wdata), .ram_rdata(ram_rdata)
  );

  mem_array #(.words_log2(words_log2)) ram (
    .clk(clk),
    .ram_en(ram_en), .ram_we(ram_we), .ram_be(ram_be),
    .ram_idx(ram_idx), .ram_wdata(ram_wdata), .ram_rdata(ram_rdata)
  );

  msg_queue #(.width(mem_resp_bits), .queue_depth(queue_depth)) resp_queue (
    .clk(clk), .rst(rst),
    .enq_val(enq_val), .enq_rdy(enq_rdy), .enq_msg(resp_enq_msg),
    .deq_val(resp_val), .deq_rdy(resp_rdy), .deq_msg(resp_deq_msg)
  );

endmodule

`default_nettype wire

/* tb_mem_server.sv */
// ------------------------------------------------
// Memory server testbench
// Table of requests checked against a shadow memory
// with random back-pressure on the response stream
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_mem_server;

  import mem_msg_pkg::*;

  localparam int wait_limit = 400;
  localparam int quiet_cycles = 20;

  logic                       clk;
  logic                       rst;
  logic                       req_val;
  logic                       req_rdy;
  logic [mem_op_bits-1:0]     req_op;
  logic [mem_opaque_bits-1:0] req_opaque;
  logic [mem_addr_bits-1:0]   req_addr;
  logic [mem_len_bits-1:0]    req_len;
  logic [mem_data_bits-1:0]   req_data;
  logic                       resp_val;
  logic                       resp_rdy;
  logic [mem_op_bits-1:0]     resp_op;
  logic [mem_opaque_bits-1:0] resp_opaque;
  logic [mem_addr_bits-1:0]   resp_addr;
  logic [mem_len_bits-1:0]    resp_len;
  logic [mem_data_bits-1:0]   resp_data;

  // Stimulus table with one entry per request
  logic [mem_op_bits-1:0]     tbl_op[$];
  logic [mem_opaque_bits-1:0] tbl_opaque[$];
  logic [mem_addr_bits-1:0]   tbl_addr[$];
  logic [mem_len_bits-1:0]    tbl_len[$];
  logic [mem_data_bits-1:0]   tbl_data[$];
  // Expected response data in the same order
  logic [mem_data_bits-1:0]   exp_data[$];

  // Word image of what the RAM should hold
  logic [mem_data_bits-1:0]   shadow [0:63];

  logic [31:0] data_state;
  logic [31:0] rdy_state;
  bit          rdy_fell;

  mem_server uut (
    .clk(clk), .rst(rst),
    .req_val(req_val), .req_rdy(req_rdy), .req_op(req_op),
    .req_opaque(req_opaque), .req_addr(req_addr), .req_len(req_len),
    .req_data(req_data),
    .resp_val(resp_val), .resp_rdy(resp_rdy), .resp_op(resp_op),
    .resp_opaque(resp_opaque), .resp_addr(resp_addr), .resp_len(resp_len),
    .resp_data(resp_data)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ------------------------------------------------
  // Helpers
  // ------------------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Bytes covered by a length
  // Zero length covers the whole word
  function automatic logic [31:0] len_mask(input logic [1:0] len);
    case (len)
      2'd1:    return 32'h0000_00ff;
      2'd2:    return 32'h0000_ffff;
      2'd3:    return 32'h00ff_ffff;
      default: return 32'hffff_ffff;
    endcase
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("[ERROR] %0d ns: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  // Append a request and its expected response data
  task automatic add_entry(input logic op, input logic [31:0] addr,
                           input logic [1:0] len, input logic [31:0] data);
    logic [5:0]  idx;
    logic [31:0] mask;
    idx = addr[7:2];
    mask = len_mask(len);
    tbl_opaque.push_back(8'(tbl_op.size()));
    tbl_op.push_back(op);
    tbl_addr.push_back(addr);
    tbl_len.push_back(len);
    tbl_data.push_back(data);
    if (op == mem_op_write) begin
      shadow[idx] = (shadow[idx] & ~mask) | (data & mask);
      exp_data.push_back(32'h0);
    end else begin
      exp_data.push_back(shadow[idx] & mask);
    end
  endtask

  task automatic build_table();
    // Full write then full read
    add_entry(mem_op_write, 32'h00, 2'd0, 32'h1122_3344);
    add_entry(mem_op_read,  32'h00, 2'd0, 32'h0);
    // Partial writes of 1, 2 and 3 bytes over full words
    add_entry(mem_op_write, 32'h04, 2'd0, 32'ha5a5_a5a5);
    add_entry(mem_op_write, 32'h04, 2'd1, 32'h0000_00ee);
    add_entry(mem_op_read,  32'h04, 2'd0, 32'h0);
    add_entry(mem_op_write, 32'h08, 2'd0, 32'hdead_beef);
    add_entry(mem_op_write, 32'h08, 2'd2, 32'h1234_5678);
    add_entry(mem_op_read,  32'h08, 2'd0, 32'h0);
    add_entry(mem_op_write, 32'h0c, 2'd0, 32'hcafe_f00d);
    add_entry(mem_op_write, 32'h0c, 2'd3, 32'h9988_7766);
    add_entry(mem_op_read,  32'h0c, 2'd0, 32'h0);
    // Partial reads
    add_entry(mem_op_read,  32'h00, 2'd1, 32'h0);
    add_entry(mem_op_read,  32'h08, 2'd2, 32'h0);
    add_entry(mem_op_read,  32'h0c, 2'd3, 32'h0);
    // Last word then an unaligned address echoed as given
    add_entry(mem_op_write, 32'hfc, 2'd0, 32'h0bad_f00d);
    add_entry(mem_op_read,  32'hfc, 2'd0, 32'h0);
    add_entry(mem_op_write, 32'h42, 2'd0, 32'h5a5a_0ff0);
    add_entry(mem_op_read,  32'h43, 2'd0, 32'h0);
    // Long burst to fill the queues
    for (int k = 0; k < 12; k++) begin
      data_state = xorshift32(data_state);
      add_entry(mem_op_write, 32'h80 + 4 * k, 2'd0, data_state);
    end
    for (int k = 0; k < 12; k++) begin
      data_state = xorshift32(data_state);
      add_entry(mem_op_write, 32'h80 + 4 * k, 2'(k % 3 + 1), data_state);
      add_entry(mem_op_read, 32'h80 + 4 * k, 2'(k % 4), 32'h0);
    end
  endtask

  // ------------------------------------------------
  // Stream processes
  // ------------------------------------------------

  // Random resp_rdy that is high about one cycle in four
  task automatic drive_ready();
    forever begin
      @(posedge clk);
      rdy_state = xorshift32(rdy_state);
      resp_rdy <= (rdy_state[1:0] == 2'b00);
    end
  endtask

  task automatic send_all();
    int waited;
    bit taken;
    for (int i = 0; i < tbl_op.size(); i++) begin
      req_val    <= 1'b1;
      req_op     <= tbl_op[i];
      req_opaque <= tbl_opaque[i];
      req_addr   <= tbl_addr[i];
      req_len    <= tbl_len[i];
      req_data   <= tbl_data[i];
      waited = 0;
      taken = 0;
      // Sampled mid-cycle
      // Transfer happens at the next rising edge
      while (!taken) begin
        @(negedge clk);
        if (req_rdy) begin
          taken = 1;
        end else begin
          rdy_fell = 1;
          waited++;
          if (waited > wait_limit) begin
            fail_run($sformatf("Timeout: request %0d was never accepted", i));
          end
        end
      end
      @(posedge clk);
    end
    req_val <= 1'b0;
  endtask

  task automatic receive_all();
    int waited;
    bit got;
    for (int i = 0; i < exp_data.size(); i++) begin
      waited = 0;
      got = 0;
      while (!got) begin
        @(negedge clk);
        if (resp_val && resp_rdy) begin
          got = 1;
        end else begin
          waited++;
          if (waited > wait_limit) begin
            fail_run($sformatf("Timeout: response %0d never arrived", i));
          end
        end
      end
      check_value("resp_op", 32'(resp_op), 32'(tbl_op[i]));
      check_value("resp_opaque", 32'(resp_opaque), 32'(tbl_opaque[i]));
      check_value("resp_addr", resp_addr, tbl_addr[i]);
      check_value("resp_len", 32'(resp_len), 32'(tbl_len[i]));
      check_value("resp_data", resp_data, exp_data[i]);
    end
    // Nothing beyond the last expected response
    repeat (quiet_cycles) begin
      @(negedge clk);
      if (resp_val) begin
        fail_run("An extra response appeared after the last expected one");
      end
    end
  endtask

  // ------------------------------------------------
  // Main sequence
  // ------------------------------------------------

  initial begin
    rst        = 1'b1;
    req_val    = 1'b0;
    req_op     = '0;
    req_opaque = '0;
    req_addr   = '0;
    req_len    = '0;
    req_data   = '0;
    resp_rdy   = 1'b0;
    data_state = 32'hef9dbddb;
    rdy_state  = 32'hef9dbddb;
    rdy_fell   = 0;
    build_table();

    repeat (16) @(posedge clk);
    rst <= 1'b0;

    // Idle state after reset
    @(negedge clk);
    check_value("resp_val", 32'(resp_val), 32'h0);
    check_value("req_rdy", 32'(req_rdy), 32'h1);

    @(posedge clk);
    fork
      drive_ready();
    join_none
    fork
      send_all();
      receive_all();
    join

    if (!rdy_fell) begin
      fail_run("req_rdy never went low although the queues should have filled");
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* src.f */
mem_msg_pkg.sv
msg_queue.sv
mem_array.sv
mem_txn_engine.sv
mem_server.sv
tb_mem_server.sv
